//--- common/tinker_pkg.sv
// Tinker core shared definitions

package tinker_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int xlen        = 64;
    localparam int num_regs    = 32;
    localparam int instr_bytes = 4;    // Fetch step
    localparam int word_bytes  = 8;    // Load/store size

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     addr_t;   // Byte address
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     imm_t;    // Literal field L

    // ------------------------------------------------------------
    // Opcodes of the integer ISA
    // ------------------------------------------------------------
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,
        op_brr    = 5'h09,    // Register offset
        op_brri   = 5'h0a,    // Literal offset
        op_brnz   = 5'h0b,
        op_halt   = 5'h0f,
        op_load   = 5'h10,
        op_mov    = 5'h11,
        op_movi   = 5'h12,    // Low 12 bits only
        op_store  = 5'h13,
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b,
        op_mul    = 5'h1c
    } opcode_t;

    // Sequencer states for one instruction pass
    typedef enum logic [2:0] {
        st_fetch     = 3'd0,
        st_decode    = 3'd1,
        st_execute   = 3'd2,
        st_memory    = 3'd3,
        st_writeback = 3'd4,
        st_halt      = 3'd5
    } state_t;

    // What an instruction does when it retires
    typedef enum logic [2:0] {
        cls_alu    = 3'd0,
        cls_load   = 3'd1,
        cls_store  = 3'd2,
        cls_branch = 3'd3,
        cls_halt   = 3'd4,
        cls_none   = 3'd5
    } op_class_t;

endpackage

//--- verilog/sequencer.sv
// Core state machine and program counter
`timescale 1ns/1ps

module sequencer #(
    parameter tinker_pkg::addr_t RESET_PC = 32'h2000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::instr_t    fetch_word,
    input  tinker_pkg::op_class_t op_class,
    input  tinker_pkg::addr_t     next_pc,
    output tinker_pkg::state_t    state,
    output tinker_pkg::addr_t     pc,
    output tinker_pkg::instr_t    instr,
    output logic                  hlt
);
    import tinker_pkg::*;

    state_t state_nxt;

    always_comb begin
        case (state)
            st_fetch:     state_nxt = st_decode;
            st_decode:    state_nxt = (op_class == cls_halt) ? st_halt : st_execute;
            st_execute:   state_nxt = st_memory;
            st_memory:    state_nxt = st_writeback;
            st_writeback: state_nxt = st_fetch;
            default:      state_nxt = st_halt;   // Halt is sticky
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == st_writeback)
                pc <= next_pc;   // One step per instruction
        end
    end

    // Instruction word held from fetch through writeback
    always_ff @(posedge clk) begin
        if (state == st_fetch)
            instr <= fetch_word;
    end

    assign hlt = (state == st_halt);

endmodule

//--- verilog/decode_unit.sv
// Instruction field decode
`timescale 1ns/1ps

module decode_unit (
    input  tinker_pkg::instr_t    instr,
    output tinker_pkg::opcode_t   opcode,
    output tinker_pkg::reg_idx_t  rd,
    output tinker_pkg::reg_idx_t  raddr_a,
    output tinker_pkg::reg_idx_t  raddr_b,
    output tinker_pkg::imm_t      imm,
    output tinker_pkg::op_class_t op_class
);
    import tinker_pkg::*;

    reg_idx_t rs;
    reg_idx_t rt;

    assign opcode = opcode_t'(instr[31:27]);
    assign rd     = instr[26:22];
    assign rs     = instr[21:17];
    assign rt     = instr[16:12];
    assign imm    = instr[11:0];

    // Register read routing
    always_comb begin
        raddr_a = rs;
        raddr_b = rt;
        case (opcode)
            op_addi, op_subi, op_shftri, op_shftli, op_movi:
                raddr_a = rd;    // Literal forms work on rd in place
            op_br, op_brr:
                raddr_a = rd;
            op_brnz, op_store: begin
                raddr_a = rd;    // Target or base address
                raddr_b = rs;    // Condition or store data
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov, op_movi,
            op_add, op_addi, op_sub, op_subi, op_mul:  op_class = cls_alu;
            op_load:                                   op_class = cls_load;
            op_store:                                  op_class = cls_store;
            op_br, op_brr, op_brri, op_brnz:           op_class = cls_branch;
            op_halt:                                   op_class = cls_halt;
            default:                                   op_class = cls_none;  // Retires as nop
        endcase
    end

endmodule

//--- verilog/register_file.sv
// 32 x 64-bit register file
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  tinker_pkg::reg_idx_t waddr,
    input  tinker_pkg::word_t    wdata,
    input  tinker_pkg::reg_idx_t raddr_a,
    input  tinker_pkg::reg_idx_t raddr_b,
    output tinker_pkg::word_t    rdata_a,
    output tinker_pkg::word_t    rdata_b
);
    import tinker_pkg::*;

    word_t regs [num_regs];

    // Single write port landing on the edge that ends writeback
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];   // Combinational reads
    assign rdata_b = regs[raddr_b];

    waddr_known: assert property (@(posedge clk) disable iff (reset)
        we |-> !$isunknown(waddr));

endmodule

//--- memory/unified_memory.sv
// Unified big-endian byte memory
`timescale 1ns/1ps

module unified_memory #(
    parameter int unsigned MEM_BYTES = 64 * 1024
) (
    input  logic               clk,
    input  tinker_pkg::addr_t  fetch_addr,
    output tinker_pkg::instr_t fetch_word,
    input  tinker_pkg::addr_t  load_addr,
    output tinker_pkg::word_t  load_data,
    input  logic               store_en,
    input  tinker_pkg::addr_t  store_addr,
    input  tinker_pkg::word_t  store_data
);
    import tinker_pkg::*;

    logic [7:0] mem [MEM_BYTES];

    // ------------------------------------------------------------
    // Reads put the most significant byte at the lowest address
    // ------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < instr_bytes; i++)
            fetch_word[$bits(instr_t)-1-8*i -: 8] = mem[fetch_addr + i];
    end

    always_comb begin
        for (int i = 0; i < word_bytes; i++)
            load_data[xlen-1-8*i -: 8] = mem[load_addr + i];
    end

    // Store lands on the edge ending the memory cycle
    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < word_bytes; i++)
                mem[store_addr + i] <= store_data[xlen-1-8*i -: 8];
        end
    end

    store_in_range: assert property (@(posedge clk)
        store_en |-> ({1'b0, store_addr} + word_bytes <= MEM_BYTES));

endmodule

//--- execute/int_alu.sv
// Integer ALU
`timescale 1ns/1ps

module int_alu (
    input  tinker_pkg::opcode_t opcode,
    input  tinker_pkg::word_t   op_a,
    input  tinker_pkg::word_t   op_b,
    input  tinker_pkg::imm_t    imm,
    output tinker_pkg::word_t   result
);
    import tinker_pkg::*;

    word_t imm_sext;
    word_t imm_zext;

    assign imm_sext = {{(xlen-$bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};
    assign imm_zext = {{(xlen-$bits(imm_t)){1'b0}}, imm};

    always_comb begin
        result = '0;
        case (opcode)
            op_add:    result = op_a + op_b;
            op_addi:   result = op_a + imm_sext;
            op_sub:    result = op_a - op_b;
            op_subi:   result = op_a - imm_zext;   // Literal is unsigned here
            op_mul:    result = op_a * op_b;       // Low 64 bits
            op_and:    result = op_a & op_b;
            op_or:     result = op_a | op_b;
            op_xor:    result = op_a ^ op_b;
            op_not:    result = ~op_a;
            op_shftr:  result = op_a >> op_b;
            op_shftri: result = op_a >> imm;
            op_shftl:  result = op_a << op_b;
            op_shftli: result = op_a << imm;
            op_mov:    result = op_a;
            op_movi:   result = {op_a[xlen-1:$bits(imm_t)], imm};   // Keeps upper bits of rd
            default:   result = '0;
        endcase
    end

endmodule

//--- execute/branch_unit.sv
// Next program counter
`timescale 1ns/1ps

module branch_unit (
    input  tinker_pkg::opcode_t opcode,
    input  tinker_pkg::addr_t   pc,
    input  tinker_pkg::word_t   op_a,
    input  tinker_pkg::word_t   op_b,
    input  tinker_pkg::imm_t    imm,
    output tinker_pkg::addr_t   next_pc
);
    import tinker_pkg::*;

    addr_t seq_pc;
    addr_t target;
    addr_t imm_off;

    assign seq_pc  = pc + instr_bytes;
    assign target  = op_a[$bits(addr_t)-1:0];   // Register r[rd]
    assign imm_off = {{($bits(addr_t)-$bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};

    always_comb begin
        case (opcode)
            op_br:   next_pc = target;
            op_brr:  next_pc = pc + target;
            op_brri: next_pc = pc + imm_off;
            op_brnz: next_pc = (op_b != '0) ? target : seq_pc;
            default: next_pc = seq_pc;
        endcase
    end

endmodule

//--- execute/commit_unit.sv
// Memory access and register writeback control
`timescale 1ns/1ps

module commit_unit (
    input  tinker_pkg::state_t    state,
    input  tinker_pkg::op_class_t op_class,
    input  tinker_pkg::reg_idx_t  rd,
    input  tinker_pkg::word_t     op_a,
    input  tinker_pkg::word_t     op_b,
    input  tinker_pkg::imm_t      imm,
    input  tinker_pkg::word_t     alu_result,
    input  tinker_pkg::word_t     load_data,
    output tinker_pkg::addr_t     mem_addr,
    output logic                  store_en,
    output tinker_pkg::word_t     store_data,
    output logic                  wb_en,
    output tinker_pkg::reg_idx_t  wb_reg,
    output tinker_pkg::word_t     wb_data
);
    import tinker_pkg::*;

    addr_t imm_off;

    // ------------------------------------------------------------
    // Effective address shared by load and store
    // ------------------------------------------------------------
    assign imm_off  = {{($bits(addr_t)-$bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};
    assign mem_addr = op_a[$bits(addr_t)-1:0] + imm_off;

    assign store_en   = (state == st_memory) && (op_class == cls_store);
    assign store_data = op_b;   // r[rs]

    // Register writeback
    assign wb_en   = (state == st_writeback) &&
                     ((op_class == cls_alu) || (op_class == cls_load));
    assign wb_reg  = rd;
    assign wb_data = (op_class == cls_load) ? load_data : alu_result;

endmodule

//--- verilog/tinker_core.sv
// Tinker multicycle core top
`timescale 1ns/1ps

module tinker_core #(
    parameter int unsigned        MEM_BYTES = 64 * 1024,
    parameter tinker_pkg::addr_t  RESET_PC  = 32'h2000
) (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 hlt,
    output logic                 wb_en,       // Retire trace
    output tinker_pkg::reg_idx_t wb_reg,
    output tinker_pkg::word_t    wb_data,
    output logic                 store_en,
    output tinker_pkg::addr_t    store_addr,  // Also the load address
    output tinker_pkg::word_t    store_data
);
    import tinker_pkg::*;

    state_t    state;
    addr_t     pc;
    addr_t     next_pc;
    instr_t    instr;
    instr_t    fetch_word;
    opcode_t   opcode;
    op_class_t op_class;
    reg_idx_t  rd;
    reg_idx_t  raddr_a;
    reg_idx_t  raddr_b;
    imm_t      imm;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_result;
    word_t     load_data;

    // ------------------------------------------------------------
    // Control path
    // ------------------------------------------------------------
    sequencer #(.RESET_PC(RESET_PC)) seq_i (
        .clk(clk), .reset(reset),
        .fetch_word(fetch_word), .op_class(op_class), .next_pc(next_pc),
        .state(state), .pc(pc), .instr(instr), .hlt(hlt)
    );

    decode_unit decode_i (
        .instr(instr), .opcode(opcode), .rd(rd),
        .raddr_a(raddr_a), .raddr_b(raddr_b), .imm(imm), .op_class(op_class)
    );

    register_file regs_i (
        .clk(clk), .reset(reset),
        .we(wb_en), .waddr(wb_reg), .wdata(wb_data),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(op_a), .rdata_b(op_b)
    );

    unified_memory #(.MEM_BYTES(MEM_BYTES)) mem_i (
        .clk(clk),
        .fetch_addr(pc), .fetch_word(fetch_word),
        .load_addr(store_addr), .load_data(load_data),
        .store_en(store_en), .store_addr(store_addr), .store_data(store_data)
    );

    // ------------------------------------------------------------
    // Execute and retire
    // ------------------------------------------------------------
    int_alu alu_i (
        .opcode(opcode), .op_a(op_a), .op_b(op_b), .imm(imm), .result(alu_result)
    );

    branch_unit branch_i (
        .opcode(opcode), .pc(pc), .op_a(op_a), .op_b(op_b), .imm(imm),
        .next_pc(next_pc)
    );

    commit_unit commit_i (
        .state(state), .op_class(op_class), .rd(rd),
        .op_a(op_a), .op_b(op_b), .imm(imm),
        .alu_result(alu_result), .load_data(load_data),
        .mem_addr(store_addr), .store_en(store_en), .store_data(store_data),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

endmodule

//--- verification/tinker_program.svh
// Test program and expected writeback trace

instr_t   prog [64];
int       prog_len;
word_t    model_r [num_regs];   // Register values the program should leave
reg_idx_t exp_reg [64];
word_t    exp_data [64];
int       exp_gap [64];         // Instructions run since the previous writeback
int       exp_test [64];
int       exp_count;
int       run_len;
int       cur_test;
addr_t    exp_st_addr;
word_t    exp_st_data;
int       alu_end;
int       mem_end;
int       ctl_end;

function automatic word_t sext(imm_t lit);
    return {{(xlen - 12){lit[11]}}, lit};
endfunction

// Append one instruction
// Skipped slots are never executed and not counted
task automatic emit(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt, imm_t lit,
                    bit counted = 1'b1);
    prog[prog_len] = {op, rd, rs, rt, lit};
    prog_len++;
    if (counted)
        run_len++;
endtask

// Instruction that retires with rd = value
task automatic step(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt, imm_t lit,
                    word_t value);
    emit(op, rd, rs, rt, lit);
    model_r[rd]         = value;
    exp_reg[exp_count]  = rd;
    exp_data[exp_count] = value;
    exp_gap[exp_count]  = run_len;
    exp_test[exp_count] = cur_test;
    exp_count++;
    run_len = 0;
endtask

task automatic build_program();
    imm_t l [7];
    imm_t sh;
    imm_t k;
    imm_t off;
    imm_t tgt;
    imm_t base_hi;
    foreach (l[i])
        l[i] = imm_t'($urandom);
    l[4][0] = 1'b1;                               // brnz condition must be nonzero
    sh      = imm_t'($urandom % 64);
    k       = imm_t'($urandom % 64);
    off     = imm_t'(($urandom % 64) * word_bytes);
    base_hi = imm_t'(prog_base >> 4);
    foreach (model_r[i])
        model_r[i] = '0;

    // ------------------------------------------------------------
    // Straight-line ALU block
    // ------------------------------------------------------------
    cur_test = t_alu;
    step(op_movi, 1, 0, 0, l[0], {model_r[1][xlen-1:12], l[0]});
    step(op_movi, 2, 0, 0, l[1], {model_r[2][xlen-1:12], l[1]});
    step(op_addi, 1, 0, 0, l[2], model_r[1] + sext(l[2]));
    step(op_subi, 2, 0, 0, l[3], model_r[2] - word_t'(l[3]));   // Zero-extended literal
    step(op_add, 3, 1, 2, 0, model_r[1] + model_r[2]);
    step(op_sub, 4, 1, 2, 0, model_r[1] - model_r[2]);
    step(op_mul, 5, 3, 4, 0, model_r[3] * model_r[4]);
    step(op_and, 6, 3, 4, 0, model_r[3] & model_r[4]);
    step(op_or, 7, 3, 4, 0, model_r[3] | model_r[4]);
    step(op_xor, 8, 3, 4, 0, model_r[3] ^ model_r[4]);
    step(op_not, 9, 3, 0, 0, ~model_r[3]);
    step(op_movi, 10, 0, 0, sh, {model_r[10][xlen-1:12], sh});
    step(op_shftr, 11, 5, 10, 0, model_r[5] >> model_r[10]);
    step(op_shftl, 12, 5, 10, 0, model_r[5] << model_r[10]);
    step(op_shftri, 6, 0, 0, k, model_r[6] >> k);
    step(op_shftli, 7, 0, 0, k, model_r[7] << k);
    step(op_mov, 13, 8, 0, 0, model_r[8]);
    alu_end = exp_count;

    // Store then load back through r14 + off
    cur_test = t_mem;
    step(op_movi, 14, 0, 0, 12'h400, {model_r[14][xlen-1:12], 12'h400});
    step(op_shftli, 14, 0, 0, 4, model_r[14] << 4);
    exp_st_addr = addr_t'(model_r[14] + sext(off));
    exp_st_data = model_r[5];
    emit(op_store, 14, 5, 0, off);
    step(op_load, 15, 14, 0, off, exp_st_data);
    mem_end = exp_count;

    // ------------------------------------------------------------
    // Control flow
    // ------------------------------------------------------------
    cur_test = t_ctl;
    emit(op_brri, 0, 0, 0, 12'd8);                 // Over the next slot
    emit(op_movi, 16, 0, 0, 12'hbad, 1'b0);
    step(op_movi, 17, 0, 0, l[4], {model_r[17][xlen-1:12], l[4]});
    step(op_movi, 18, 0, 0, base_hi, {model_r[18][xlen-1:12], base_hi});
    step(op_shftli, 18, 0, 0, 4, model_r[18] << 4);
    tgt = imm_t'(instr_bytes * (prog_len + 3));    // Slot after the skipped one
    step(op_addi, 18, 0, 0, tgt, model_r[18] + sext(tgt));
    emit(op_brnz, 18, 17, 0, 0);                   // Taken
    emit(op_movi, 19, 0, 0, 12'hbad, 1'b0);
    step(op_movi, 20, 0, 0, l[5], {model_r[20][xlen-1:12], l[5]});
    emit(op_brnz, 18, 0, 0, 0);                    // r0 is zero so falls through
    step(op_movi, 21, 0, 0, l[6], {model_r[21][xlen-1:12], l[6]});
    ctl_end = exp_count;
    emit(op_halt, 0, 0, 0, 0);
    emit(op_movi, 22, 0, 0, 12'hbad, 1'b0);        // Never reached
endtask

//--- verification/tinker_tb.sv
// Tinker core testbench
`timescale 1ns/1ps

module tinker_tb;
    import tinker_pkg::*;

    localparam int    clk_period   = 4;
    localparam int    reset_cycles = 8;
    localparam int    halt_window  = 50;    // Cycles watched after halt
    localparam addr_t prog_base    = 32'h2000;
    localparam int    t_reset      = 0;
    localparam int    t_alu        = 1;
    localparam int    t_mem        = 2;
    localparam int    t_ctl        = 3;
    localparam int    t_halt       = 4;
    localparam int    num_tests    = 5;

    logic     clk;
    logic     reset;
    logic     hlt;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     store_en;
    addr_t    store_addr;
    word_t    store_data;
    int       wb_idx;       // Writebacks seen so far
    int       since_wb;     // Cycles since the last writeback
    int       st_count;
    bit       image_ready;
    int       errors [num_tests];
    string    test_name [num_tests] = '{"reset", "alu", "memory", "control", "halt"};

    `include "tinker_program.svh"

    tinker_core #(.RESET_PC(prog_base)) dut_i (
        .clk(clk), .reset(reset), .hlt(hlt),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
        .store_en(store_en), .store_addr(store_addr), .store_data(store_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(int t, string what, logic [63:0] expected,
                                   logic [63:0] actual);
        errors[t]++;
        $display("Fail %s %s: expected %h actual %h", test_name[t], what, expected, actual);
    endtask

    task automatic report_problem(int t, string msg);
        errors[t]++;
        $display("Error in %s test: %s", test_name[t], msg);
    endtask

    task automatic finish_test(int t);
        $display("Test %-8s %s, %0d error(s)", test_name[t],
                 (errors[t] == 0) ? "ok" : "FAILED", errors[t]);
    endtask

    task automatic wait_for_retires(int n);
        wait (wb_idx >= n);
        repeat (2) @(posedge clk);    // Let the last checks settle
    endtask

    // Program words go in big-endian at the reset PC
    task automatic load_image();
        for (int i = 0; i < prog_len; i++)
            for (int b = 0; b < instr_bytes; b++)
                dut_i.mem_i.mem[prog_base + instr_bytes * i + b] = prog[i][31 - 8 * b -: 8];
    endtask

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_idx   <= 0;
            since_wb <= 0;
            st_count <= 0;
        end else begin
            wb_idx   <= wb_en ? wb_idx + 1 : wb_idx;
            since_wb <= wb_en ? 1 : since_wb + 1;
            if (store_en)
                st_count <= st_count + 1;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !hlt && !wb_en && !store_en)
        else report_problem(t_reset, "hlt, wb_en or store_en high during reset");

    first_retire: assert property (@(posedge clk)
        $fell(reset) |-> (!hlt && !wb_en && !store_en) ##1 !wb_en ##1 !wb_en ##1 !wb_en
        ##1 wb_en)
        else report_problem(t_reset, "first writeback not in the fifth cycle after reset");

    wb_in_table: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> wb_idx < exp_count)
        else report_problem(t_ctl, "more writebacks than the program produces");

    wb_reg_ok: assert property (@(posedge clk) disable iff (reset)
        wb_en && wb_idx < exp_count |-> wb_reg == exp_reg[wb_idx])
        else report_mismatch(exp_test[$sampled(wb_idx)], "wb_reg",
                             exp_reg[$sampled(wb_idx)], $sampled(wb_reg));

    wb_data_ok: assert property (@(posedge clk) disable iff (reset)
        wb_en && wb_idx < exp_count |-> wb_data == exp_data[wb_idx])
        else report_mismatch(exp_test[$sampled(wb_idx)], "wb_data",
                             exp_data[$sampled(wb_idx)], $sampled(wb_data));

    wb_spacing: assert property (@(posedge clk) disable iff (reset)
        wb_en && wb_idx > 0 && wb_idx < exp_count |-> since_wb == 5 * exp_gap[wb_idx])
        else report_mismatch(exp_test[$sampled(wb_idx)], "writeback spacing",
                             5 * exp_gap[$sampled(wb_idx)], $sampled(since_wb));

    store_addr_ok: assert property (@(posedge clk) disable iff (reset)
        store_en |-> store_addr == exp_st_addr)
        else report_mismatch(t_mem, "store_addr", exp_st_addr, $sampled(store_addr));

    store_data_ok: assert property (@(posedge clk) disable iff (reset)
        store_en |-> store_data == exp_st_data)
        else report_mismatch(t_mem, "store_data", exp_st_data, $sampled(store_data));

    // Halt follows a writeback, so fetch and decode come before hlt
    halt_timing: assert property (@(posedge clk) disable iff (reset)
        $rose(hlt) |-> since_wb == 3)
        else report_mismatch(t_halt, "cycles to hlt", 3, $sampled(since_wb));

    halt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else report_problem(t_halt, "hlt dropped without reset");

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !wb_en && !store_en)
        else report_problem(t_halt, "writeback or store while halted");

    initial begin
        int total;
        int clean;
        total = 0;
        clean = 0;
        reset = 1'b1;
        void'($urandom(32'h10e9ff0e));
        build_program();
        load_image();
        image_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        wait_for_retires(1);
        finish_test(t_reset);
        wait_for_retires(alu_end);
        finish_test(t_alu);
        wait_for_retires(mem_end);
        store_count_ok: assert (st_count == 1)
            else report_mismatch(t_mem, "store count", 1, st_count);
        finish_test(t_mem);
        wait_for_retires(ctl_end);
        finish_test(t_ctl);
        wait (hlt === 1'b1);
        repeat (halt_window) @(posedge clk);
        retire_count_ok: assert (wb_idx == exp_count)
            else report_mismatch(t_halt, "writeback count", exp_count, wb_idx);
        finish_test(t_halt);

        for (int t = 0; t < num_tests; t++) begin
            total += errors[t];
            if (errors[t] == 0)
                clean++;
        end
        $display("Tests %0d, clean %0d, with errors %0d, failed checks %0d",
                 num_tests, clean, num_tests - clean, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Twice the program at five cycles each, plus reset
    initial begin
        wait (image_ready);
        #(2 * prog_len * 5 * clk_period + reset_cycles * clk_period);
        $display("Watchdog expired before the program finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verification
common/tinker_pkg.sv
verilog/sequencer.sv
verilog/decode_unit.sv
verilog/register_file.sv
memory/unified_memory.sv
execute/int_alu.sv
execute/branch_unit.sv
execute/commit_unit.sv
verilog/tinker_core.sv
verification/tinker_tb.sv
